/* Bender.yml */
package:
  name: cmd_engine

sources:
  - verilog/cmd_pkg.sv
  - verilog/vlq_decoder.sv
  - verilog/cmd_table.sv
  - verilog/cmd_dispatch.sv
  - verilog/vlq_encoder.sv
  - verilog/unit_system.sv
  - verilog/unit_gpio.sv
  - verilog/cmd_top.sv
  - target: simulation
    files:
      - verif/cmd_tb.sv

/* build.f */
verilog/cmd_pkg.sv
verilog/vlq_decoder.sv
verilog/cmd_table.sv
verilog/cmd_dispatch.sv
verilog/vlq_encoder.sv
verilog/unit_system.sv
verilog/unit_gpio.sv
verilog/cmd_top.sv
verif/cmd_tb.sv

/* verif/cmd_tb.sv */
`timescale 1ns/1ps

module cmd_tb import cmd_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 4000; // About twice the full sequence
	localparam int RSP_WAIT = 200;
	localparam logic [31:0] BOUNDS [9] = '{
		32'h0000_005f, 32'h0000_0060, 32'hffff_ffe0, 32'hffff_ffdf, 32'h0000_2fff,
		32'h0000_3000, 32'h0bff_ffff, 32'h0c00_0000, 32'hffff_ffff
	};

	logic             clk;
	logic             rst;
	logic             in_valid;
	logic [7:0]       in_data;
	logic             rsp_valid;
	logic [7:0]       rsp_data;
	logic             rsp_end;
	logic [7:0]       rsp_len;
	logic [NGPIO-1:0] gpio;

	int               cycle = 0;
	int               frame_bytes = 0;   // rsp bytes since the last rsp_end
	logic [31:0]      rng_state = 32'd96778;
	logic [7:0]       rsp_q [$];
	logic [31:0]      rsp_vals [MAX_PARAMS];
	int               rsp_lens [MAX_PARAMS];
	int               rsp_nvals;
	logic [NGPIO-1:0] gpio_model = '0;

	cmd_top u_cmd_top (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_end   (rsp_end),
		.rsp_len   (rsp_len),
		.gpio      (gpio)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Helpers
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic expect_equal(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else
			report_failure($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// Shortest signed VLQ, the leading group must not look like a sign it lacks
	function automatic int vlq_len(input logic [31:0] v);
		logic signed [63:0] s;
		int n;
		s = {{32{v[31]}}, v};
		n = 5;
		for (int k = 4; k >= 1; k--) begin
			if (s >= -(64'sd1 <<< (7 * k - 2)) && s < (64'sd3 <<< (7 * k - 2))) begin
				n = k;
			end
		end
		return n;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// Host side
	task automatic send_frame(input logic [7:0] cmd, input int nargs,
			input logic [31:0] a0, input logic [31:0] a1);
		logic [7:0]         bytes [$];
		logic [31:0]        args [2];
		logic signed [63:0] s;
		int                 n;
		args[0] = a0;
		args[1] = a1;
		bytes.push_back(cmd);
		for (int k = 0; k < nargs; k++) begin
			s = {{32{args[k][31]}}, args[k]};
			n = vlq_len(args[k]);
			for (int i = n - 1; i >= 0; i--) begin
				bytes.push_back({i != 0, 7'(s >>> (7 * i))}); // Continuation on all but last
			end
		end
		foreach (bytes[i]) begin
			@(posedge clk);
			in_valid <= 1'b1;
			in_data <= bytes[i];
			if (xorshift32() % 4 == 0) begin
				@(posedge clk); // Idle gap inside the frame
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// Wait for rsp_end, then split the collected bytes into parameters
	task automatic await_response();
		int          waited;
		int          nv;
		int          blen;
		logic        first;
		logic [63:0] acc;
		logic [7:0]  b;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!rsp_end && waited < RSP_WAIT);
		assert (rsp_end) else report_failure("No rsp_end arrived after the command");
		expect_equal("rsp_len", rsp_len, rsp_q.size());
		nv = 0;
		blen = 0;
		first = 1'b1;
		acc = '0;
		foreach (rsp_q[i]) begin
			b = rsp_q[i];
			acc = first ? {{57{b[6] & b[5]}}, b[6:0]} : {acc[56:0], b[6:0]};
			first = 1'b0;
			blen++;
			if (!b[7]) begin
				if (nv < MAX_PARAMS) begin
					rsp_vals[nv] = acc[31:0];
					rsp_lens[nv] = blen;
				end
				nv++;
				first = 1'b1;
				blen = 0;
			end
		end
		assert (first) else report_failure("Response ended inside a parameter");
		assert (nv <= MAX_PARAMS) else report_failure("Response holds too many parameters");
		rsp_nvals = nv;
		for (int i = 0; i < nv; i++) begin
			expect_equal("rsp param byte count", rsp_lens[i], vlq_len(rsp_vals[i]));
		end
		rsp_q.delete();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Command checks
	task automatic check_version();
		send_frame(CMD_GET_VERSION, 0, '0, '0);
		await_response();
		expect_equal("get_version param count", rsp_nvals, 2);
		expect_equal("get_version rsp id", rsp_vals[0], RSP_GET_VERSION);
		expect_equal("version", rsp_vals[1], VERSION);
	endtask

	task automatic sync_and_check(input logic [31:0] hi, input logic [31:0] lo);
		int          start;
		logic [63:0] synced;
		logic [63:0] now_t;
		logic [63:0] diff;
		synced = {hi, lo};
		send_frame(CMD_SYNC_TIME, 2, lo, hi);
		start = cycle;
		repeat (8) @(posedge clk);
		expect_equal("rsp bytes after sync_time", rsp_q.size(), 0);
		send_frame(CMD_GET_TIME, 0, '0, '0);
		await_response();
		expect_equal("get_time param count", rsp_nvals, 3);
		expect_equal("get_time rsp id", rsp_vals[0], RSP_GET_TIME);
		now_t = {rsp_vals[2], rsp_vals[1]};
		diff = now_t - synced; // Wraps huge if the time fell below the synced value
		assert (diff <= 64'(cycle - start + 64)) else
			report_failure($sformatf("Mismatch get_time: got 0x%0h expected 0x%0h plus up to 0x%0h",
				now_t, synced, cycle - start + 64));
	endtask

	task automatic set_pin(input logic [31:0] pin, input logic [31:0] val);
		send_frame(CMD_SET_DIGITAL_OUT, 2, pin, val);
		if (pin < 32'(NGPIO)) begin
			gpio_model[pin[2:0]] = val[0];
		end
		repeat (8) @(posedge clk);
		expect_equal("gpio", gpio, gpio_model);
		expect_equal("rsp bytes after set_digital_out", rsp_q.size(), 0);
	endtask

	task automatic send_unknown(input logic [7:0] cmd);
		send_frame(cmd, 0, '0, '0);
		repeat (8) @(posedge clk);
		expect_equal("rsp bytes after unknown command", rsp_q.size(), 0);
		expect_equal("gpio", gpio, gpio_model);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Response monitor and run limit
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			report_failure("Timeout, the test sequence did not finish within the cycle limit");
		end
		if (rst || rsp_end) begin
			frame_bytes <= 0;
		end else if (rsp_valid) begin
			frame_bytes <= frame_bytes + 1;
		end
		if (!rst && rsp_valid) begin
			rsp_q.push_back(rsp_data);
		end
	end

	a_quiet_reset: assert property (@(posedge clk)
		cycle >= 1 && cycle < 16 |-> !rsp_valid && !rsp_end)
		else report_failure("Response output was active during or right after reset");

	a_end_has_bytes: assert property (@(posedge clk) disable iff (rst)
		rsp_end |-> frame_bytes != 0)
		else report_failure("rsp_end came without any response byte before it");

	// ~~~~~~~~~~~~~~~~~~~~
	// Test sequence
	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_data = 8'h00;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		repeat (8) @(posedge clk); // Quiet window after reset

		check_version();

		repeat (4) begin
			sync_and_check(xorshift32(), xorshift32());
		end

		repeat (40) begin
			set_pin(xorshift32() % 12, xorshift32()); // Some pins out of range
		end

		foreach (BOUNDS[i]) begin
			set_pin(BOUNDS[i], 32'd1);
			set_pin(xorshift32() % NGPIO, BOUNDS[i]);
			sync_and_check(BOUNDS[i], BOUNDS[i]);
		end

		send_unknown(8'h07);
		send_unknown(8'hc3);
		check_version();

		$display("All tests passed");
		$finish;
	end

endmodule

/* verilog/cmd_dispatch.sv */
`timescale 1ns/1ps

module cmd_dispatch import cmd_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      in_valid,
	input  logic [7:0]                in_data,
	output logic                      arg_byte,
	input  logic                      arg_valid,
	input  logic [31:0]               arg_data,
	output logic [7:0]                cmd_id,
	input  cmd_entry_t                entry,
	output logic [NUNITS-1:0]         cmd_start,
	output unit_cmd_t                 unit_cmd,
	input  logic [NUNITS-1:0]         param_valid,
	input  param_t [NUNITS-1:0]       param,
	input  logic [NUNITS-1:0]         cmd_done,
	output logic                      enc_start,
	output logic                      enc_raw,
	output logic [31:0]               enc_value,
	input  logic                      enc_done,
	output logic                      rsp_end,
	output logic [7:0]                rsp_len
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ARGS,
		ST_DISPATCH,
		ST_WAIT_DONE,
		ST_SEND_ID,
		ST_SEND_PARAMS,
		ST_END
	} state_t;

	state_t    state;
	unit_cmd_t cur;                  // Command id and collected arguments
	param_t    pbuf [MAX_PARAMS];    // Parameters waiting for the encoder
	logic [1:0] arg_cnt;
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	logic       enc_busy;            // Encoder is emitting bytes
	logic       cmd_phase;           // Ready for a command byte
	logic       param_ok;
	logic       sending;

	assign cmd_phase = state == ST_IDLE || state == ST_END;
	assign param_ok = state == ST_DISPATCH || state == ST_WAIT_DONE;
	assign sending = state == ST_SEND_ID || state == ST_SEND_PARAMS;

	// Table sees the live byte between frames, the held id otherwise
	assign cmd_id = cmd_phase ? in_data : cur.cmd;
	assign arg_byte = in_valid && state == ST_ARGS;
	assign unit_cmd = cur;

	always_comb begin
		cmd_start = '0;
		if (state == ST_DISPATCH) begin
			cmd_start[entry.unit] = 1'b1;
		end
	end

	assign enc_start = sending && !enc_busy; // One parameter at a time
	assign enc_raw = state == ST_SEND_ID;
	assign enc_value = pbuf[rd_ptr].data;
	assign rsp_end = state == ST_END;

	// ~~~~~~~~~~~~~~~~~~~~
	// Control FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			arg_cnt <= 2'd0;
			wr_ptr <= 2'd0;
			rd_ptr <= 2'd0;
			enc_busy <= 1'b0;
			rsp_len <= 8'd0;
		end else begin
			if (enc_busy) begin
				rsp_len <= rsp_len + 8'd1; // One byte per busy cycle
			end
			if (enc_start) begin
				enc_busy <= 1'b1;
			end else if (enc_done) begin
				enc_busy <= 1'b0;
			end
			if (param_ok && param_valid[entry.unit]) begin
				wr_ptr <= wr_ptr + 2'd1;
			end
			case (state)
				ST_IDLE, ST_END: begin
					state <= ST_IDLE;
					if (in_valid && entry.valid) begin // Unknown ids are dropped here
						arg_cnt <= 2'd0;
						wr_ptr <= 2'd0;
						rd_ptr <= 2'd0;
						rsp_len <= 8'd0;
						state <= (entry.nargs == 2'd0) ? ST_DISPATCH : ST_ARGS;
					end
				end
				ST_ARGS: begin
					if (arg_valid) begin
						arg_cnt <= arg_cnt + 2'd1;
						if (arg_cnt + 2'd1 == entry.nargs) begin
							state <= ST_DISPATCH;
						end
					end
				end
				ST_DISPATCH: begin
					state <= ST_WAIT_DONE;
				end
				ST_WAIT_DONE: begin
					if (cmd_done[entry.unit]) begin
						state <= entry.has_rsp ? ST_SEND_ID : ST_IDLE;
					end
				end
				ST_SEND_ID: begin
					if (enc_done) begin
						rd_ptr <= 2'd1;
						state <= pbuf[0].last ? ST_END : ST_SEND_PARAMS;
					end
				end
				ST_SEND_PARAMS: begin
					if (enc_done) begin
						if (pbuf[rd_ptr].last) begin
							state <= ST_END;
						end else begin
							rd_ptr <= rd_ptr + 2'd1;
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Argument and parameter storage
	always_ff @(posedge clk) begin
		if (cmd_phase && in_valid) begin
			cur.cmd <= in_data;
		end
		if (state == ST_ARGS && arg_valid) begin
			cur.args[arg_cnt[0]] <= arg_data;
		end
		if (param_ok && param_valid[entry.unit]) begin
			pbuf[wr_ptr] <= param[entry.unit];
		end
	end

	// Units finish only the command that was handed to them
	a_done_pending: assert property (@(posedge clk) disable iff (rst)
		|cmd_done |-> state == ST_WAIT_DONE && cmd_done[entry.unit]);

	// Host keeps quiet while a command runs or answers
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> state == ST_IDLE || state == ST_ARGS || state == ST_END);

endmodule

/* verilog/cmd_pkg.sv */
package cmd_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Command ids, host to FPGA
	localparam logic [7:0] CMD_GET_VERSION     = 8'd0;
	localparam logic [7:0] CMD_SYNC_TIME       = 8'd1;
	localparam logic [7:0] CMD_GET_TIME        = 8'd2;
	localparam logic [7:0] CMD_SET_DIGITAL_OUT = 8'd15;

	// Response ids, first byte of every answer
	localparam logic [7:0] RSP_GET_VERSION = 8'd0;
	localparam logic [7:0] RSP_GET_TIME    = 8'd1;

	// ~~~~~~~~~~~~~~~~~~~~
	// Execution units
	localparam logic UNIT_SYSTEM = 1'b0;
	localparam logic UNIT_GPIO   = 1'b1;
	localparam int   NUNITS      = 2;

	// ~~~~~~~~~~~~~~~~~~~~
	// Sizes
	localparam int MAX_ARGS   = 2;
	localparam int MAX_PARAMS = 3; // Response id counts as one
	localparam int NGPIO      = 8;

	localparam logic [31:0] VERSION = 32'h0001_0004; // Reported by get_version

	// One row of the command table
	typedef struct packed {
		logic       valid;
		logic       unit;
		logic [1:0] nargs;
		logic       has_rsp;
	} cmd_entry_t;

	// Command handed to a unit, argument 0 in the low word
	typedef struct packed {
		logic [7:0]                 cmd;
		logic [MAX_ARGS-1:0][31:0] args;
	} unit_cmd_t;

	// Response parameter from a unit
	typedef struct packed {
		logic [31:0] data;
		logic        last; // Final parameter of the response
	} param_t;

endpackage

/* verilog/cmd_table.sv */
`timescale 1ns/1ps

module cmd_table import cmd_pkg::*; (
	input  logic [7:0] cmd_id,
	output cmd_entry_t entry
);

	// Unit, argument count and response flag per command
	always_comb begin
		entry = '0; // Unknown ids come back invalid
		case (cmd_id)
			CMD_GET_VERSION: begin
				entry = '{valid: 1'b1, unit: UNIT_SYSTEM, nargs: 2'd0, has_rsp: 1'b1};
			end
			CMD_SYNC_TIME: begin
				entry = '{valid: 1'b1, unit: UNIT_SYSTEM, nargs: 2'd2, has_rsp: 1'b0};
			end
			CMD_GET_TIME: begin
				entry = '{valid: 1'b1, unit: UNIT_SYSTEM, nargs: 2'd0, has_rsp: 1'b1};
			end
			CMD_SET_DIGITAL_OUT: begin
				entry = '{valid: 1'b1, unit: UNIT_GPIO, nargs: 2'd2, has_rsp: 1'b0};
			end
			default: begin
				entry = '0;
			end
		endcase
	end

endmodule

/* verilog/cmd_top.sv */
`timescale 1ns/1ps

module cmd_top import cmd_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  logic [7:0]       in_data,
	output logic             rsp_valid,
	output logic [7:0]       rsp_data,
	output logic             rsp_end,
	output logic [7:0]       rsp_len,
	output logic [NGPIO-1:0] gpio
);

	logic                arg_byte;
	logic                arg_valid;
	logic [31:0]         arg_data;
	logic [7:0]          cmd_id;
	cmd_entry_t          entry;
	logic [NUNITS-1:0]   cmd_start;
	wire  [NUNITS-1:0]   cmd_done;
	wire  [NUNITS-1:0]   param_valid;
	wire  param_t [NUNITS-1:0] param;
	unit_cmd_t           unit_cmd;
	logic                enc_start;
	logic                enc_raw;
	logic [31:0]         enc_value;
	logic                enc_done;

	// GPIO unit never answers
	assign param_valid[UNIT_GPIO] = 1'b0;
	assign param[UNIT_GPIO] = '0;

	vlq_decoder u_vlq_decoder (
		.clk       (clk),
		.rst       (rst),
		.arg_byte  (arg_byte),
		.in_data   (in_data),
		.arg_valid (arg_valid),
		.arg_data  (arg_data)
	);

	cmd_table u_cmd_table (
		.cmd_id (cmd_id),
		.entry  (entry)
	);

	cmd_dispatch u_cmd_dispatch (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.arg_byte    (arg_byte),
		.arg_valid   (arg_valid),
		.arg_data    (arg_data),
		.cmd_id      (cmd_id),
		.entry       (entry),
		.cmd_start   (cmd_start),
		.unit_cmd    (unit_cmd),
		.param_valid (param_valid),
		.param       (param),
		.cmd_done    (cmd_done),
		.enc_start   (enc_start),
		.enc_raw     (enc_raw),
		.enc_value   (enc_value),
		.enc_done    (enc_done),
		.rsp_end     (rsp_end),
		.rsp_len     (rsp_len)
	);

	vlq_encoder u_vlq_encoder (
		.clk       (clk),
		.rst       (rst),
		.enc_start (enc_start),
		.enc_raw   (enc_raw),
		.enc_value (enc_value),
		.enc_done  (enc_done),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data)
	);

	unit_system u_unit_system (
		.clk         (clk),
		.rst         (rst),
		.cmd_start   (cmd_start[UNIT_SYSTEM]),
		.unit_cmd    (unit_cmd),
		.param_valid (param_valid[UNIT_SYSTEM]),
		.param       (param[UNIT_SYSTEM]),
		.cmd_done    (cmd_done[UNIT_SYSTEM])
	);

	unit_gpio u_unit_gpio (
		.clk       (clk),
		.rst       (rst),
		.cmd_start (cmd_start[UNIT_GPIO]),
		.unit_cmd  (unit_cmd),
		.cmd_done  (cmd_done[UNIT_GPIO]),
		.gpio      (gpio)
	);

endmodule

/* verilog/unit_gpio.sv */
`timescale 1ns/1ps

module unit_gpio import cmd_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             cmd_start,
	input  unit_cmd_t        unit_cmd,
	output logic             cmd_done,
	output logic [NGPIO-1:0] gpio
);

	logic pin_ok;

	// Negative pin numbers wrap to large values and fail here too
	assign pin_ok = unit_cmd.args[0] < 32'(NGPIO);

	always_ff @(posedge clk) begin
		if (rst) begin
			gpio <= '0;
			cmd_done <= 1'b0;
		end else begin
			cmd_done <= cmd_start; // Always finishes next cycle
			if (cmd_start && unit_cmd.cmd == CMD_SET_DIGITAL_OUT && pin_ok) begin
				gpio[unit_cmd.args[0][$clog2(NGPIO)-1:0]] <= unit_cmd.args[1][0];
			end
		end
	end

	// Table routes only set_digital_out to this unit
	a_gpio_cmd: assert property (@(posedge clk) disable iff (rst)
		cmd_start |-> unit_cmd.cmd == CMD_SET_DIGITAL_OUT);

endmodule

/* verilog/unit_system.sv */
`timescale 1ns/1ps

module unit_system import cmd_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      cmd_start,
	input  unit_cmd_t unit_cmd,
	output logic      param_valid,
	output param_t    param,
	output logic      cmd_done
);

	logic [63:0] systime;
	logic [63:0] snap;    // Time captured at get_time start
	logic [7:0]  cur_cmd;
	logic [1:0]  step;    // 0 idle, then one step per data word

	always_ff @(posedge clk) begin
		if (rst) begin
			systime <= 64'd0;
			step <= 2'd0;
		end else begin
			systime <= systime + 64'd1;
			if (cmd_start) begin
				step <= 2'd1;
				if (unit_cmd.cmd == CMD_SYNC_TIME) begin
					systime <= {unit_cmd.args[1], unit_cmd.args[0]}; // High word is arg 1
				end
			end else if (step == 2'd1 && cur_cmd == CMD_GET_TIME) begin
				step <= 2'd2;
			end else begin
				step <= 2'd0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_start) begin
			cur_cmd <= unit_cmd.cmd;
			snap <= systime;
		end
	end

	// Response id goes out with the start, data words follow
	always_comb begin
		param_valid = 1'b0;
		param = '0;
		cmd_done = 1'b0;
		if (cmd_start && unit_cmd.cmd == CMD_GET_VERSION) begin
			param_valid = 1'b1;
			param.data = {24'd0, RSP_GET_VERSION};
		end
		if (cmd_start && unit_cmd.cmd == CMD_GET_TIME) begin
			param_valid = 1'b1;
			param.data = {24'd0, RSP_GET_TIME};
		end
		if (step == 2'd1) begin
			case (cur_cmd)
				CMD_GET_VERSION: begin
					param_valid = 1'b1;
					param = '{data: VERSION, last: 1'b1};
					cmd_done = 1'b1;
				end
				CMD_GET_TIME: begin
					param_valid = 1'b1;
					param.data = snap[31:0];
				end
				default: begin
					cmd_done = 1'b1; // sync_time has nothing to say
				end
			endcase
		end
		if (step == 2'd2) begin
			param_valid = 1'b1;
			param = '{data: snap[63:32], last: 1'b1};
			cmd_done = 1'b1;
		end
	end

endmodule

/* verilog/vlq_decoder.sv */
`timescale 1ns/1ps

module vlq_decoder (
	input  logic        clk,
	input  logic        rst,
	input  logic        arg_byte,
	input  logic [7:0]  in_data,
	output logic        arg_valid,
	output logic [31:0] arg_data
);

	logic [31:0] acc;
	logic [2:0]  nbytes; // Bytes taken so far for this argument
	logic        neg;

	assign neg = in_data[6] & in_data[5]; // Negative when leading group starts 11
	assign arg_data = acc;

	always_ff @(posedge clk) begin
		if (rst) begin
			nbytes <= 3'd0;
			arg_valid <= 1'b0;
		end else begin
			arg_valid <= arg_byte && !in_data[7];
			if (arg_byte) begin
				if (in_data[7]) begin
					nbytes <= nbytes + 3'd1;
				end else begin
					nbytes <= 3'd0; // Next byte opens a new argument
				end
			end
		end
	end

	// Seven value bits gathered per byte
	always_ff @(posedge clk) begin
		if (arg_byte) begin
			if (nbytes == 3'd0) begin
				acc <= {{25{neg}}, in_data[6:0]};
			end else begin
				acc <= {acc[24:0], in_data[6:0]};
			end
		end
	end

	// A 32-bit argument never needs more than five groups
	a_arg_len: assert property (@(posedge clk) disable iff (rst)
		arg_byte && nbytes == 3'd4 |-> !in_data[7]);

endmodule

/* verilog/vlq_encoder.sv */
`timescale 1ns/1ps

module vlq_encoder (
	input  logic        clk,
	input  logic        rst,
	input  logic        enc_start,
	input  logic        enc_raw,
	input  logic [31:0] enc_value,
	output logic        enc_done,
	output logic        rsp_valid,
	output logic [7:0]  rsp_data
);

	logic [34:0] ext;    // Value aligned so its first group sits at the top
	logic [2:0]  nbytes; // Shortest encoding length
	logic [34:0] sh;
	logic [2:0]  left;   // Bytes still to go after the current one

	// Drop leading groups that only repeat the sign
	always_comb begin
		ext = {{3{enc_value[31]}}, enc_value};
		nbytes = 3'd5;
		for (int i = 0; i < 4; i++) begin
			if (nbytes == 3'(5 - i) && (ext[34:26] == 9'h1ff || ext[34:26] < 9'd3)) begin
				ext = {ext[27:0], 7'd0};
				nbytes = nbytes - 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid <= 1'b0;
			enc_done <= 1'b0;
			left <= 3'd0;
		end else if (enc_start) begin
			rsp_valid <= 1'b1;
			enc_done <= enc_raw || nbytes == 3'd1;
			left <= enc_raw ? 3'd0 : nbytes - 3'd1; // Raw id is one byte
		end else begin
			rsp_valid <= left != 3'd0;
			enc_done <= left == 3'd1;
			if (left != 3'd0) begin
				left <= left - 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (enc_start) begin
			rsp_data <= enc_raw ? enc_value[7:0] : {nbytes != 3'd1, ext[34:28]};
			sh <= {ext[27:0], 7'd0};
		end else if (left != 3'd0) begin
			rsp_data <= {left != 3'd1, sh[34:28]}; // Continuation bit unless last
			sh <= {sh[27:0], 7'd0};
		end
	end

endmodule
